/* rtl/dma_rd_settings.svh */
`ifndef DMA_RD_SETTINGS_SVH
`define DMA_RD_SETTINGS_SVH

// CNET queue setup
`define DMA_NUM_Q         16    // Queues reporting packets
`define DMA_Q_BITS        4     // Queue number width

// Read path buffering
`define DMA_FIFO_DEPTH    4     // Words between CNET and PCI

// Packet limits
`define DMA_MAX_PKT_BYTES 2048  // Largest legal read packet
`define DMA_WORD_CNT_BITS 10    // Holds max packet in words

`endif

/* rtl/dma_rd_pkg.sv */
`include "dma_rd_settings.svh"

package dma_rd_pkg;

   // One data word, same width on CNET and PCI sides
   typedef logic [31:0] data_word_t;

   // Queue number and one-bit-per-queue mask
   typedef logic [`DMA_Q_BITS-1:0] queue_t;
   typedef logic [`DMA_NUM_Q-1:0]  qmask_t;

   // Byte count from the low half of the length word
   typedef logic [15:0] pkt_size_t;

   // Packet length in 32-bit words
   typedef logic [`DMA_WORD_CNT_BITS-1:0] word_cnt_t;

   // Active-high byte enables for one word
   typedef logic [3:0] byte_en_t;

   // Host word address, byte address bits 31:2
   typedef logic [29:0] host_addr_t;

endpackage

/* rtl/dma_rd_rr_arb.sv */
`timescale 1ns/1ps
`include "dma_rd_settings.svh"

module dma_rd_rr_arb (
   input  logic               clk,
   input  logic               rst,
   input  dma_rd_pkg::qmask_t dma_pkt_avail,  // Queues holding a packet
   input  logic               grant_take,     // Winner is being served
   output logic               grant_vld,
   output dma_rd_pkg::queue_t grant_q
);

   import dma_rd_pkg::*;

   localparam int NUM_Q = `DMA_NUM_Q;

   queue_t ptr;   // Highest priority queue this round

   // Search from ptr upward with wrap, first hit wins
   always_comb
   begin
      int idx;
      grant_vld = 1'b0;
      grant_q   = '0;
      // Walk backwards so the lowest offset from ptr is written last
      for (int i = NUM_Q - 1; i >= 0; i--)
      begin
         idx = (int'(ptr) + i) % NUM_Q;
         if (dma_pkt_avail[idx])
         begin
            grant_vld = 1'b1;
            grant_q   = queue_t'(idx);
         end
      end
   end

   // Priority moves one past the served queue
   always_ff @(posedge clk)
   begin
      if (rst)
         ptr <= '0;                          // Queue 0 first after reset
      else if (grant_take)
      begin
         if (int'(grant_q) == NUM_Q - 1)
            ptr <= '0;                       // Wrap to the first queue
         else
            ptr <= grant_q + 1'b1;
      end
   end

endmodule

/* rtl/dma_rd_ctrl.sv */
`timescale 1ns/1ps
`include "dma_rd_settings.svh"

module dma_rd_ctrl (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  dma_rd_owner,
   input  logic                  grant_vld,
   input  dma_rd_pkg::queue_t    grant_q,
   input  logic                  dma_empty,        // CNET buffer has no word
   input  logic                  fifo_full,
   input  logic                  cnet_left_zero,
   input  logic                  pci_done,         // Last word accepted by PCI core
   input  dma_rd_pkg::pkt_size_t len_size,
   output logic                  grant_take,       // Also the CNET read request
   output dma_rd_pkg::queue_t    dma_rd_request_q,
   output logic                  len_take,
   output logic                  cnet_take,
   output dma_rd_pkg::queue_t    dma_rd_mac,
   output logic                  dma_rd_done,
   output logic                  dma_rd_size_err,
   output logic                  xfer_active
);

   import dma_rd_pkg::*;

   localparam pkt_size_t MAX_SIZE = pkt_size_t'(`DMA_MAX_PKT_BYTES);

   typedef enum logic [2:0] {
      ST_IDLE,       // Wait for ownership and a packet
      ST_WAIT_LEN,   // Request sent, length word pending
      ST_XFER,       // Moving payload words
      ST_FINISH,     // One cycle done strobe
      ST_HOLD        // Wait for the host to take the buffer back
   } state_t;

   state_t state;
   logic   size_ok;

   // ==============================
   // Strobes
   // ==============================

   // Zero bytes or oversize packets are rejected
   assign size_ok = (len_size != '0) && (len_size <= MAX_SIZE);

   // Skip the request cycle itself, CNET answers later
   assign len_take  = (state == ST_WAIT_LEN) && !grant_take && !dma_empty;

   // Payload read gated by remaining count, FIFO room and CNET data
   assign cnet_take = (state == ST_XFER) && !cnet_left_zero && !fifo_full && !dma_empty;

   assign xfer_active = (state == ST_XFER);
   assign dma_rd_done = (state == ST_FINISH);   // Cycle after dma_complete

   // ==============================
   // Packet FSM
   // ==============================

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         state            <= ST_IDLE;
         grant_take       <= 1'b0;
         dma_rd_request_q <= '0;
         dma_rd_mac       <= '0;
         dma_rd_size_err  <= 1'b0;
      end
      else
      begin
         grant_take      <= 1'b0;                 // Pulses by default
         dma_rd_size_err <= 1'b0;
         case (state)
            ST_IDLE:
               if (dma_rd_owner && grant_vld)
               begin
                  grant_take       <= 1'b1;
                  dma_rd_request_q <= grant_q;
                  state            <= ST_WAIT_LEN;
               end
            ST_WAIT_LEN:
               if (len_take)
               begin
                  if (size_ok)
                     state <= ST_XFER;
                  else
                  begin
                     dma_rd_size_err <= 1'b1;     // Rest of packet stays in CNET
                     state           <= ST_HOLD;
                  end
               end
            ST_XFER:
               if (pci_done)
               begin
                  dma_rd_mac <= dma_rd_request_q; // Report where it came from
                  state      <= ST_FINISH;
               end
            ST_FINISH:
               state <= ST_HOLD;
            ST_HOLD:
               if (!dma_rd_owner)
                  state <= ST_IDLE;               // Host took the buffer back
            default:
               state <= ST_IDLE;
         endcase
      end
   end

endmodule

/* rtl/dma_rd_cntr.sv */
`timescale 1ns/1ps
`include "dma_rd_settings.svh"

module dma_rd_cntr (
   input  logic                   clk,
   input  logic                   rst,
   input  dma_rd_pkg::data_word_t dma_rd_addr,
   input  dma_rd_pkg::data_word_t dma_data_frm_cnet,
   input  logic                   len_take,       // Length word on the CNET bus
   input  logic                   cnet_take,      // Payload word read from CNET
   input  logic                   word_accept,    // Payload word sent to host
   output dma_rd_pkg::pkt_size_t  dma_rd_size,
   output dma_rd_pkg::pkt_size_t  len_size,
   output logic                   cnet_left_zero,
   output logic                   pci_last,
   output dma_rd_pkg::byte_en_t   last_be,
   output dma_rd_pkg::host_addr_t dma_addr
);

   import dma_rd_pkg::*;

   localparam int CNT_BITS = `DMA_WORD_CNT_BITS;

   word_cnt_t   cnet_cnt;     // Words still to read from CNET
   word_cnt_t   pci_cnt;      // Words still to hand to the PCI core
   logic [16:0] size_rnd;     // Bytes plus 3 for round up
   word_cnt_t   load_words;

   assign len_size   = dma_data_frm_cnet[15:0];   // Byte count field
   assign size_rnd   = {1'b0, len_size} + 17'd3;
   assign load_words = size_rnd[CNT_BITS+1:2];    // ceil(bytes / 4)

   assign cnet_left_zero = (cnet_cnt == '0);
   assign pci_last       = (pci_cnt == word_cnt_t'(1));

   // Partial last word keeps the low bytes
   always_comb
   begin
      case (dma_rd_size[1:0])
         2'd1:    last_be = 4'b0001;
         2'd2:    last_be = 4'b0011;
         2'd3:    last_be = 4'b0111;
         default: last_be = 4'b1111;
      endcase
   end

   // ==============================
   // Counters and address pointer
   // ==============================

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         cnet_cnt    <= '0;
         pci_cnt     <= '0;
         dma_rd_size <= '0;
         dma_addr    <= '0;
      end
      else if (len_take)
      begin
         cnet_cnt    <= load_words;
         pci_cnt     <= load_words;
         dma_rd_size <= len_size;
         dma_addr    <= dma_rd_addr[31:2];        // Word aligned start only
      end
      else
      begin
         if (cnet_take)
            cnet_cnt <= cnet_cnt - 1'b1;
         if (word_accept)
         begin
            pci_cnt  <= pci_cnt - 1'b1;
            dma_addr <= dma_addr + 1'b1;          // Next host word
         end
      end
   end

endmodule

/* rtl/dma_rd_fifo.sv */
`timescale 1ns/1ps
`include "dma_rd_settings.svh"

module dma_rd_fifo (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   push,
   input  dma_rd_pkg::data_word_t din,
   input  logic                   pop,
   output dma_rd_pkg::data_word_t dout,   // Head word, valid when not empty
   output logic                   full,
   output logic                   empty
);

   import dma_rd_pkg::*;

   localparam int DEPTH  = `DMA_FIFO_DEPTH;
   localparam int PTR_W  = $clog2(DEPTH);
   localparam int CNT_W  = $clog2(DEPTH + 1);

   data_word_t       mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr, rd_ptr;
   logic [CNT_W-1:0] count;          // Words held

   assign dout  = mem[rd_ptr];
   assign full  = (count == CNT_W'(DEPTH));
   assign empty = (count == '0);

   // Storage
   always_ff @(posedge clk)
   begin
      if (push)
         mem[wr_ptr] <= din;
   end

   // Pointers wrap at DEPTH, count tracks push minus pop
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         if (push && !pop)
            count <= count + 1'b1;
         else if (pop && !push)
            count <= count - 1'b1;   // Both at once leaves count alone
      end
   end

endmodule

/* rtl/dma_rd_pci_xfer.sv */
`timescale 1ns/1ps

module dma_rd_pci_xfer (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   xfer_active,   // Control block in transfer
   input  logic                   fifo_empty,
   input  logic                   pci_last,      // Head word is the packet's last
   input  dma_rd_pkg::data_word_t fifo_dout,
   input  dma_rd_pkg::byte_en_t   last_be,
   input  logic                   dma_src_en,    // Core takes the presented word
   output logic                   dma_request,
   output logic                   dma_vld,
   output logic                   dma_complete,
   output logic                   word_accept,
   output dma_rd_pkg::data_word_t dma_data,
   output dma_rd_pkg::byte_en_t   dma_be
);

   import dma_rd_pkg::*;

   localparam byte_en_t BE_ALL = '1;

   // Present the FIFO head while the request is up
   assign dma_vld      = dma_request && !fifo_empty;
   assign word_accept  = dma_vld && dma_src_en;      // Pops the FIFO too
   assign dma_complete = word_accept && pci_last;
   assign dma_data     = fifo_dout;
   assign dma_be       = pci_last ? last_be : BE_ALL;

   // ==============================
   // Request level
   // ==============================

   always_ff @(posedge clk)
   begin
      if (rst)
         dma_request <= 1'b0;
      else if (dma_complete)
         dma_request <= 1'b0;            // Last word gone
      else if (xfer_active)
         dma_request <= 1'b1;            // Data phase of this packet
   end

endmodule

/* rtl/dma_rd_engine.sv */
`timescale 1ns/1ps

module dma_rd_engine (
   input  logic                   clk,
   input  logic                   rst,
   // Host registers
   input  dma_rd_pkg::data_word_t dma_rd_addr,       // Byte address, low bits ignored
   input  logic                   dma_rd_owner,      // 1 = card owns read buffer
   output dma_rd_pkg::pkt_size_t  dma_rd_size,       // Size of last packet
   output dma_rd_pkg::queue_t     dma_rd_mac,        // Queue of last packet
   output logic                   dma_rd_done,
   output logic                   dma_rd_size_err,
   // CNET side
   input  dma_rd_pkg::qmask_t     dma_pkt_avail,
   output logic                   dma_rd_request,
   output dma_rd_pkg::queue_t     dma_rd_request_q,
   input  dma_rd_pkg::data_word_t dma_data_frm_cnet, // FWFT head word
   input  logic                   dma_empty,
   output logic                   dma_rd_en,
   // PCI core master side
   output dma_rd_pkg::data_word_t dma_data,
   output dma_rd_pkg::byte_en_t   dma_be,
   output dma_rd_pkg::host_addr_t dma_addr,
   output logic                   dma_vld,
   output logic                   dma_request,
   output logic                   dma_complete,
   input  logic                   dma_src_en
);

   import dma_rd_pkg::*;

   // ==============================
   // Local wires
   // ==============================

   logic       grant_vld;           // Some queue has a packet
   queue_t     grant_q;             // Winning queue
   logic       len_take;            // Length word taken this cycle
   logic       cnet_take;           // Payload word taken this cycle
   logic       cnet_left_zero;      // All payload words read from CNET
   logic       pci_last;            // PCI side on final word
   logic       xfer_active;
   pkt_size_t  len_size;            // Length field for the size check
   byte_en_t   last_be;
   logic       fifo_full, fifo_empty;
   data_word_t fifo_dout;
   logic       word_accept;         // Word taken by PCI core, also pops FIFO

   // Length word and payload words both strobe the CNET buffer
   assign dma_rd_en = len_take | cnet_take;

   // ==============================
   // Arbiter and control
   // ==============================

   dma_rd_rr_arb i_rr_arb (
      .clk           (clk),
      .rst           (rst),
      .dma_pkt_avail (dma_pkt_avail),
      .grant_take    (dma_rd_request),
      .grant_vld     (grant_vld),
      .grant_q       (grant_q)
   );

   dma_rd_ctrl i_ctrl (
      .clk              (clk),
      .rst              (rst),
      .dma_rd_owner     (dma_rd_owner),
      .grant_vld        (grant_vld),
      .grant_q          (grant_q),
      .dma_empty        (dma_empty),
      .fifo_full        (fifo_full),
      .cnet_left_zero   (cnet_left_zero),
      .pci_done         (dma_complete),
      .len_size         (len_size),
      .grant_take       (dma_rd_request),   // Request pulse doubles as grant ack
      .dma_rd_request_q (dma_rd_request_q),
      .len_take         (len_take),
      .cnet_take        (cnet_take),
      .dma_rd_mac       (dma_rd_mac),
      .dma_rd_done      (dma_rd_done),
      .dma_rd_size_err  (dma_rd_size_err),
      .xfer_active      (xfer_active)
   );

   // ==============================
   // Datapath
   // ==============================

   dma_rd_cntr i_cntr (
      .clk               (clk),
      .rst               (rst),
      .dma_rd_addr       (dma_rd_addr),
      .dma_data_frm_cnet (dma_data_frm_cnet),
      .len_take          (len_take),
      .cnet_take         (cnet_take),
      .word_accept       (word_accept),
      .dma_rd_size       (dma_rd_size),
      .len_size          (len_size),
      .cnet_left_zero    (cnet_left_zero),
      .pci_last          (pci_last),
      .last_be           (last_be),
      .dma_addr          (dma_addr)
   );

   dma_rd_fifo i_fifo (
      .clk   (clk),
      .rst   (rst),
      .push  (cnet_take),
      .din   (dma_data_frm_cnet),
      .pop   (word_accept),
      .dout  (fifo_dout),
      .full  (fifo_full),
      .empty (fifo_empty)
   );

   dma_rd_pci_xfer i_pci_xfer (
      .clk          (clk),
      .rst          (rst),
      .xfer_active  (xfer_active),
      .fifo_empty   (fifo_empty),
      .pci_last     (pci_last),
      .fifo_dout    (fifo_dout),
      .last_be      (last_be),
      .dma_src_en   (dma_src_en),
      .dma_request  (dma_request),
      .dma_vld      (dma_vld),
      .dma_complete (dma_complete),
      .word_accept  (word_accept),
      .dma_data     (dma_data),
      .dma_be       (dma_be)
   );

endmodule

/* bench/dma_rd_tb.sv */
`timescale 1ns/1ps
`include "dma_rd_settings.svh"

module dma_rd_tb;

   import dma_rd_pkg::*;

   localparam int TEST_WORDS  = 166;                      // CNET words loaded over all tests
   localparam int TIMEOUT_CYC = TEST_WORDS * 20 + 2000;

   // DUT ports
   logic       clk, rst;
   data_word_t dma_rd_addr;
   logic       dma_rd_owner;
   pkt_size_t  dma_rd_size;
   queue_t     dma_rd_mac;
   logic       dma_rd_done, dma_rd_size_err;
   qmask_t     dma_pkt_avail;
   logic       dma_rd_request;
   queue_t     dma_rd_request_q;
   data_word_t dma_data_frm_cnet;
   logic       dma_empty, dma_rd_en;
   data_word_t dma_data;
   byte_en_t   dma_be;
   host_addr_t dma_addr;
   logic       dma_vld, dma_request, dma_complete, dma_src_en;

   // CNET buffers as one word list per queue with head and tail index
   data_word_t  cnet_mem [`DMA_NUM_Q][128];
   int          head [`DMA_NUM_Q];
   int          tail [`DMA_NUM_Q];
   int          cur_q      = 0;        // Queue the CNET is presenting
   logic        stall_mode = 1'b0;     // Random dma_empty gaps
   logic        src_gaps   = 1'b0;     // Random dma_src_en gaps
   logic [31:0] lfsr       = 32'hc4a7;

   // Words accepted by the PCI core and the event log
   data_word_t cap_data [256];
   host_addr_t cap_addr [256];
   byte_en_t   cap_be   [256];
   logic       cap_cmp  [256];
   int         cap_n = 0, done_cnt = 0, serr_cnt = 0, req_cnt = 0, preq_cyc = 0;
   int         cmp_cyc = 0, done_cyc = 0, cyc = 0;
   queue_t     last_req_q = '0;
   int         err_cnt = 0, fail_cnt = 0;

   dma_rd_engine i_dma_rd_engine (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;                             // 100 ns period
   end

   // ==============================
   // Random bits and compare tasks
   // ==============================

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic take_bit();
      lfsr = lfsr_step(lfsr);
      return lfsr[0];
   endfunction

   function automatic data_word_t random_word();
      data_word_t w;
      for (int b = 0; b < 32; b++)
         w[b] = take_bit();                               // One step per bit
      return w;
   endfunction

   // Enables cover only the bytes left over for the last word
   function automatic byte_en_t exp_last_be(input int size);
      int       nbytes;
      byte_en_t be;
      nbytes = size - 4 * ((size + 3) / 4 - 1);           // Bytes in the last word
      be     = '0;
      for (int b = 0; b < nbytes; b++)
         be[b] = 1'b1;
      return be;
   endfunction

   task automatic value_error(input string what, input logic [31:0] got, input logic [31:0] exp);
      $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
      err_cnt = err_cnt + 1;
   endtask

   task automatic protocol_error(input string msg);
      $display("Failure at %0t ns: %s", $time, msg);
      fail_cnt = fail_cnt + 1;
   endtask

   task automatic check_word(input data_word_t got, input data_word_t exp, input string what);
      if (got !== exp)
         value_error(what, got, exp);
   endtask

   task automatic check_addr(input host_addr_t got, input host_addr_t exp, input string what);
      if (got !== exp)
         value_error(what, 32'(got), 32'(exp));
   endtask

   task automatic check_be(input byte_en_t got, input byte_en_t exp, input string what);
      if (got !== exp)
         value_error(what, 32'(got), 32'(exp));
   endtask

   task automatic check_q(input queue_t got, input queue_t exp, input string what);
      if (got !== exp)
         value_error(what, 32'(got), 32'(exp));
   endtask

   task automatic check_size(input pkt_size_t got, input pkt_size_t exp, input string what);
      if (got !== exp)
         value_error(what, 32'(got), 32'(exp));
   endtask

   // ==============================
   // CNET model and PCI monitor
   // ==============================

   always @(posedge clk)
   begin : cnet_model
      qmask_t avail;
      logic   gap;
      if (dma_rd_en)
         head[cur_q] = head[cur_q] + 1;                   // Word on the bus was taken
      if (dma_rd_request)
         cur_q = int'(dma_rd_request_q);
      for (int q = 0; q < `DMA_NUM_Q; q++)
         avail[q] = (head[q] != tail[q]);
      gap = 1'b0;
      if (stall_mode)
         gap = take_bit();
      dma_pkt_avail     <= avail;
      dma_data_frm_cnet <= cnet_mem[cur_q][head[cur_q]];  // First word fall through
      dma_empty         <= (head[cur_q] == tail[cur_q]) || gap;
      if (src_gaps)
         dma_src_en <= take_bit();
      else
         dma_src_en <= 1'b1;
   end

   always @(posedge clk)
   begin : pci_monitor
      cyc <= cyc + 1;
      if (cyc == TIMEOUT_CYC)
      begin
         $display("Timeout after %0d cycles, an expected done or size error never came", cyc);
         $display("Errors: %0d value mismatches, %0d other failures", err_cnt, fail_cnt);
         $display("Testbench failed");
         $finish;
      end
      else if (!rst)
      begin
         if (dma_vld && dma_src_en)                       // Word accepted by the core
         begin
            cap_data[cap_n] <= dma_data;
            cap_addr[cap_n] <= dma_addr;
            cap_be[cap_n]   <= dma_be;
            cap_cmp[cap_n]  <= dma_complete;
            cap_n           <= cap_n + 1;
         end
         if (dma_complete)
            cmp_cyc <= cyc;
         if (dma_rd_done)
         begin
            done_cnt <= done_cnt + 1;
            done_cyc <= cyc;
         end
         if (dma_rd_size_err)
            serr_cnt <= serr_cnt + 1;
         if (dma_rd_request)
         begin
            req_cnt    <= req_cnt + 1;
            last_req_q <= dma_rd_request_q;
         end
         if (dma_request)
            preq_cyc <= preq_cyc + 1;                     // Cycles with PCI request up
      end
   end

   // ==============================
   // Packet tasks
   // ==============================

   task automatic load_packet(input int q, input int size, input int nwords, output int base);
      base = tail[q];
      cnet_mem[q][tail[q]] = {16'h0000, pkt_size_t'(size)}; // Length word
      tail[q] = tail[q] + 1;
      for (int i = 0; i < nwords; i++)
      begin
         cnet_mem[q][tail[q]] = random_word();
         tail[q] = tail[q] + 1;
      end
   endtask

   // Raise owner and wait for done before checking every word the host got
   task automatic serve_packet(input int q, input int base, input int size,
                               input data_word_t addr);
      int         c0, d0, nw;
      host_addr_t a0;
      c0 = cap_n;
      d0 = done_cnt;
      nw = (size + 3) / 4;
      a0 = addr[31:2];
      @(posedge clk);
      dma_rd_addr  <= addr;
      dma_rd_owner <= 1'b1;
      while (done_cnt == d0)
         @(posedge clk);
      if (cap_n - c0 != nw)
         protocol_error($sformatf("queue %0d moved %0d words, not %0d", q, cap_n - c0, nw));
      for (int i = 0; i < nw && c0 + i < cap_n; i++)
      begin
         check_word(cap_data[c0+i], cnet_mem[q][base+1+i], $sformatf("word %0d data", i));
         check_addr(cap_addr[c0+i], a0 + host_addr_t'(i), $sformatf("word %0d address", i));
         check_be(cap_be[c0+i], (i == nw - 1) ? exp_last_be(size) : 4'b1111,
                  $sformatf("word %0d byte enables", i));
         if (cap_cmp[c0+i] != (i == nw - 1))
            protocol_error($sformatf("dma_complete wrong on word %0d", i));
      end
      if (done_cyc != cmp_cyc + 1)
         protocol_error("dma_rd_done did not come one cycle after dma_complete");
      check_q(last_req_q, queue_t'(q), "requested queue");
      check_q(dma_rd_mac, queue_t'(q), "dma_rd_mac");
      check_size(dma_rd_size, pkt_size_t'(size), "dma_rd_size");
      dma_rd_owner <= 1'b0;                               // Host takes the buffer back
      repeat (2) @(posedge clk);
   endtask

   // Bad length word gives a size error and no data phase
   task automatic reject_packet(input int q, input int size);
      int base, s0, d0, p0;
      s0 = serr_cnt;
      d0 = done_cnt;
      p0 = preq_cyc;
      load_packet(q, size, 0, base);
      @(posedge clk);
      dma_rd_owner <= 1'b1;
      while (serr_cnt == s0)
         @(posedge clk);
      repeat (8) @(posedge clk);                          // Room for a stray request
      check_q(last_req_q, queue_t'(q), "rejected queue");
      if (serr_cnt != s0 + 1)
         protocol_error($sformatf("size %0d held dma_rd_size_err for %0d cycles",
                                  size, serr_cnt - s0));
      if (done_cnt != d0 || preq_cyc != p0)
         protocol_error($sformatf("size %0d still started a transfer", size));
      dma_rd_owner <= 1'b0;
      repeat (2) @(posedge clk);
   endtask

   // ==============================
   // Directed tests
   // ==============================

   task automatic test_round_robin();
      int b2a, b2b, b7, b12;
      load_packet(2, 32, 8, b2a);
      load_packet(7, 32, 8, b7);
      load_packet(12, 32, 8, b12);
      serve_packet(2, b2a, 32, 32'h0002_0000);
      load_packet(2, 32, 8, b2b);                         // Must wait behind 7 and 12
      serve_packet(7, b7, 32, 32'h0002_0100);
      serve_packet(12, b12, 32, 32'h0002_0200);
      serve_packet(2, b2b, 32, 32'h0002_0300);
   endtask

   task automatic test_partial_last();
      int base;
      for (int s = 61; s <= 63; s++)
      begin
         load_packet(9, s, (s + 3) / 4, base);
         serve_packet(9, base, s, 32'h0004_0000 + 32'(s) * 32'h100);
      end
   endtask

   task automatic test_back_pressure();
      int base;
      load_packet(10, 200, 50, base);
      stall_mode <= 1'b1;
      src_gaps   <= 1'b1;
      serve_packet(10, base, 200, 32'h8000_1000);
      stall_mode <= 1'b0;
      src_gaps   <= 1'b0;
   endtask

   task automatic test_owner_low();
      int base, r0;
      r0 = req_cnt;
      load_packet(1, 32, 8, base);
      repeat (50) @(posedge clk);
      if (req_cnt != r0)
         protocol_error("dma_rd_request came while dma_rd_owner was low");
   endtask

   initial
   begin
      int base;
      for (int q = 0; q < `DMA_NUM_Q; q++)
      begin
         head[q] = 0;
         tail[q] = 0;
      end
      rst               <= 1'b1;
      dma_rd_addr       <= '0;
      dma_rd_owner      <= 1'b0;
      dma_pkt_avail     <= '0;
      dma_data_frm_cnet <= '0;
      dma_empty         <= 1'b1;
      dma_src_en        <= 1'b0;
      repeat (3) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      if (dma_rd_request | dma_rd_en | dma_request | dma_vld | dma_complete |
          dma_rd_done | dma_rd_size_err)
         protocol_error("control outputs not low after reset");
      load_packet(5, 64, 16, base);                       // Single full-word packet
      serve_packet(5, base, 64, 32'h0001_0100);
      reject_packet(14, 0);
      reject_packet(15, `DMA_MAX_PKT_BYTES + 1);
      test_round_robin();
      test_partial_last();
      test_back_pressure();
      test_owner_low();
      $display("Errors: %0d value mismatches, %0d other failures", err_cnt, fail_cnt);
      if (err_cnt == 0 && fail_cnt == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

/* dma_rd.f */
+incdir+rtl
rtl/dma_rd_pkg.sv
rtl/dma_rd_rr_arb.sv
rtl/dma_rd_ctrl.sv
rtl/dma_rd_cntr.sv
rtl/dma_rd_fifo.sv
rtl/dma_rd_pci_xfer.sv
rtl/dma_rd_engine.sv
bench/dma_rd_tb.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the DMA read testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f dma_rd.f --top-module dma_rd_tb -o dma_rd_sim

out=$(./obj_dir/dma_rd_sim)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
   exit 0
fi
exit 1
